// File: verilog/bpuPkg.sv
/*
 * Branch predictor package.
 * Table and stack sizes, branch kinds, the 2-bit counter and the table entry.
 */
package bpuPkg;

    // table index taken from pc[INDEX_W+1:2]
    localparam int INDEX_W = 6;
    localparam int TAG_W = 32 - INDEX_W - 2;

    // return stack
    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = $clog2(RAS_DEPTH);
    // pointer value at which the stack counts as full
    localparam logic [RAS_PTR_W-1:0] RAS_FULL = RAS_PTR_W'(RAS_DEPTH - 1);

    typedef enum logic [1:0] {
        brNone = 2'b00,
        brImme = 2'b01,   // conditional branch
        brCall = 2'b10,
        brRetn = 2'b11
    } branchTypeT;

    // upper bit set means predict taken
    typedef enum logic [1:0] {
        cntSNT = 2'b00,
        cntWNT = 2'b01,
        cntWT  = 2'b10,
        cntST  = 2'b11
    } counterT;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      target;
        branchTypeT       kind;
        counterT          count;
    } bhtEntryT;

endpackage

// File: verilog/bhtRam.sv
/*
 * Branch target table memory.
 * Direct mapped, asynchronous read, registered write, valid bit per entry.
 */
module bhtRam #(
    parameter type payloadT = logic [31:0]
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       wrEn,
    input  logic [bpuPkg::INDEX_W-1:0] wrIndex,
    input  payloadT                    wrData,
    input  logic [bpuPkg::INDEX_W-1:0] rdIndex,
    output payloadT                    rdData,
    output logic                       rdValid
);

    payloadT                          mem [2**bpuPkg::INDEX_W];
    logic [2**bpuPkg::INDEX_W-1:0]    entryValid;

    // valid flags, cleared so a cold table never hits
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
        end else if (wrEn) begin
            entryValid[wrIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIndex] <= wrData;
        end
    end

    // read sees the old entry during a same-cycle write
    assign rdData  = mem[rdIndex];
    assign rdValid = entryValid[rdIndex];

endmodule

// File: verilog/counterUpdate.sv
/*
 * Write-back entry builder.
 * Forms tag, target and kind from a resolved branch and steps the 2-bit counter.
 */
module counterUpdate (
    input  logic [31:0]        resolvePc,
    input  logic [31:0]        resolveTarget,
    input  bpuPkg::branchTypeT resolveType,
    input  logic               resolveTaken,
    input  logic               resolveHit,
    input  bpuPkg::counterT    resolveCount,
    output bpuPkg::bhtEntryT   wrEntry
);

    bpuPkg::counterT nextCount;

    always_comb begin
        // fresh entry starts weak in the observed direction
        nextCount = resolveTaken ? bpuPkg::cntWT : bpuPkg::cntWNT;
        if (resolveHit) begin
            case (resolveCount)
                bpuPkg::cntSNT: nextCount = resolveTaken ? bpuPkg::cntWNT : bpuPkg::cntSNT;
                bpuPkg::cntWNT: nextCount = resolveTaken ? bpuPkg::cntWT  : bpuPkg::cntSNT;
                bpuPkg::cntWT:  nextCount = resolveTaken ? bpuPkg::cntST  : bpuPkg::cntWNT;
                bpuPkg::cntST:  nextCount = resolveTaken ? bpuPkg::cntST  : bpuPkg::cntWT;
                default:        nextCount = bpuPkg::cntWNT;
            endcase
        end
    end

    assign wrEntry = '{
        tag:    resolvePc[31:bpuPkg::INDEX_W+2],
        target: resolveTarget,
        kind:   resolveType,
        count:  nextCount
    };

endmodule

// File: verilog/returnStack.sv
/*
 * Return address stack.
 * Pushed by resolved calls, popped by resolved returns, with a same-cycle bypass.
 */
module returnStack (
    input  logic               clk,
    input  logic               arstN,
    input  logic               resolveValid,
    input  logic [31:0]        resolvePc,
    input  bpuPkg::branchTypeT resolveType,
    input  logic [31:0]        fetchPc,
    output logic [31:0]        rasTop
);

    logic [31:0]                  stack [bpuPkg::RAS_DEPTH];
    logic [bpuPkg::RAS_PTR_W-1:0] ptr;
    logic [bpuPkg::RAS_PTR_W-1:0] pushSlot;
    logic                         push;
    logic                         pop;
    logic                         full;
    logic                         empty;
    logic [31:0]                  pushAddr;

    assign push     = resolveValid && (resolveType == bpuPkg::brCall);
    assign pop      = resolveValid && (resolveType == bpuPkg::brRetn);
    assign full     = !empty && (ptr == bpuPkg::RAS_FULL);
    assign pushSlot = empty ? '0 : ptr + 1'b1;
    // return lands past the delay slot
    assign pushAddr = resolvePc + 32'd8;

    // ptr indexes the top entry, empty marks a stack with no entries
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ptr   <= '0;
            empty <= 1'b1;
        end else if (push && !full) begin
            ptr   <= pushSlot;
            empty <= 1'b0;
        end else if (pop && !empty) begin
            if (ptr == '0) begin
                empty <= 1'b1;
            end else begin
                ptr <= ptr - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            stack[pushSlot] <= pushAddr;
        end
    end

    always_comb begin
        if (push) begin
            rasTop = pushAddr;
        end else if (empty) begin
            rasTop = fetchPc + 32'd8;
        end else begin
            rasTop = stack[ptr];
        end
    end

    // pointer saturates at both ends and never wraps
    apNoOverflow: assert property (@(posedge clk) disable iff (!arstN)
        ptr == bpuPkg::RAS_FULL |=> ptr != '0);
    apNoUnderflow: assert property (@(posedge clk) disable iff (!arstN)
        ptr == '0 |=> ptr != bpuPkg::RAS_FULL);

endmodule

// File: verilog/predictCtrl.sv
/*
 * Fetch register and prediction select.
 * Captures the table lookup and stack top, then picks target and taken flag.
 */
module predictCtrl (
    input  logic               clk,
    input  logic               arstN,
    input  logic               fetchWr,
    input  logic               fetchFlush,
    input  logic [31:0]        fetchPc,
    input  bpuPkg::bhtEntryT   rdEntry,
    input  logic               rdValid,
    input  logic [31:0]        rasTop,
    output logic [31:0]        predTarget,
    output logic               predTaken,
    output bpuPkg::branchTypeT predType,
    output bpuPkg::counterT    predCount,
    output logic               predHit,
    output logic               predValid
);

    bpuPkg::bhtEntryT            regEntry;
    logic                        regEntryValid;
    logic [bpuPkg::TAG_W-1:0]    regPcTag;
    logic [31:0]                 regRasTop;
    logic [31:0]                 regPcAdd8;
    logic                        regValid;

    // flush wins over a write, stall holds everything
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regEntry      <= '0;
            regEntryValid <= 1'b0;
            regPcTag      <= '0;
            regRasTop     <= '0;
            regPcAdd8     <= '0;
            regValid      <= 1'b0;
        end else if (fetchFlush) begin
            regEntry      <= '0;
            regEntryValid <= 1'b0;
            regPcTag      <= '0;
            regRasTop     <= '0;
            regPcAdd8     <= '0;
            regValid      <= 1'b0;
        end else if (fetchWr) begin
            regEntry      <= rdEntry;
            regEntryValid <= rdValid;
            regPcTag      <= fetchPc[31:bpuPkg::INDEX_W+2];
            regRasTop     <= rasTop;
            regPcAdd8     <= fetchPc + 32'd8;
            regValid      <= 1'b1;
        end
    end

    assign predHit = regEntryValid && (regEntry.tag == regPcTag);

    always_comb begin
        // fall-through unless a hit says otherwise
        predTarget = regPcAdd8;
        predTaken  = 1'b0;
        if (predHit) begin
            case (regEntry.kind)
                bpuPkg::brCall: begin
                    predTarget = regEntry.target;
                    predTaken  = 1'b1;
                end
                bpuPkg::brRetn: begin
                    predTarget = regRasTop;
                    predTaken  = 1'b1;
                end
                bpuPkg::brImme: begin
                    if (regEntry.count[1]) begin
                        predTarget = regEntry.target;
                        predTaken  = 1'b1;
                    end
                end
                default: begin
                    predTaken = 1'b0;
                end
            endcase
        end
    end

    assign predType  = predHit ? regEntry.kind : bpuPkg::brNone;
    assign predCount = regEntry.count;
    assign predValid = regValid;

    apTakenHit: assert property (@(posedge clk) disable iff (!arstN)
        predTaken |-> predHit && predValid);

endmodule

// File: verilog/branchPredictor.sv
/*
 * Branch prediction unit top level.
 * Ties the target table, counter update, return stack and fetch control together.
 */
module branchPredictor (
    input  logic               clk,
    input  logic               arstN,
    input  logic [31:0]        fetchPc,
    input  logic               fetchWr,
    input  logic               fetchFlush,
    input  logic               resolveValid,
    input  logic [31:0]        resolvePc,
    input  logic [31:0]        resolveTarget,
    input  bpuPkg::branchTypeT resolveType,
    input  logic               resolveTaken,
    input  logic               resolveHit,
    input  bpuPkg::counterT    resolveCount,
    output logic [31:0]        predTarget,
    output logic               predTaken,
    output bpuPkg::branchTypeT predType,
    output bpuPkg::counterT    predCount,
    output logic               predHit,
    output logic               predValid
);

    bpuPkg::bhtEntryT wrEntry;
    bpuPkg::bhtEntryT rdEntry;
    logic             rdValid;
    logic [31:0]      rasTop;

    counterUpdate counterUpdate_i (
        .resolvePc     (resolvePc),
        .resolveTarget (resolveTarget),
        .resolveType   (resolveType),
        .resolveTaken  (resolveTaken),
        .resolveHit    (resolveHit),
        .resolveCount  (resolveCount),
        .wrEntry       (wrEntry)
    );

    bhtRam #(
        .payloadT (bpuPkg::bhtEntryT)
    ) bhtRam_i (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (resolveValid),
        .wrIndex (resolvePc[bpuPkg::INDEX_W+1:2]),
        .wrData  (wrEntry),
        .rdIndex (fetchPc[bpuPkg::INDEX_W+1:2]),
        .rdData  (rdEntry),
        .rdValid (rdValid)
    );

    returnStack returnStack_i (
        .clk          (clk),
        .arstN        (arstN),
        .resolveValid (resolveValid),
        .resolvePc    (resolvePc),
        .resolveType  (resolveType),
        .fetchPc      (fetchPc),
        .rasTop       (rasTop)
    );

    predictCtrl predictCtrl_i (
        .clk        (clk),
        .arstN      (arstN),
        .fetchWr    (fetchWr),
        .fetchFlush (fetchFlush),
        .fetchPc    (fetchPc),
        .rdEntry    (rdEntry),
        .rdValid    (rdValid),
        .rasTop     (rasTop),
        .predTarget (predTarget),
        .predTaken  (predTaken),
        .predType   (predType),
        .predCount  (predCount),
        .predHit    (predHit),
        .predValid  (predValid)
    );

    // counterUpdate only sees real branch kinds from execute
    apResolveKind: assert property (@(posedge clk) disable iff (!arstN)
        resolveValid |-> resolveType != bpuPkg::brNone);

endmodule

// File: bench/bpuModel.svh
/*
 * Reference model of the branch predictor.
 * Keeps its own table, valid flags and return stack, and forms expected outputs.
 */

bpuPkg::bhtEntryT   mdlTable [2**bpuPkg::INDEX_W];
logic               mdlValid [2**bpuPkg::INDEX_W];
logic [31:0]        mdlStack [bpuPkg::RAS_DEPTH];
int                 mdlDepth;

// expected outputs after the most recent edge
logic [31:0]        expTarget;
logic               expTaken;
bpuPkg::branchTypeT expType;
bpuPkg::counterT    expCount;
logic               expHit;
logic               expValid;

function automatic int indexOf(input logic [31:0] pc);
    return int'(pc[bpuPkg::INDEX_W+1:2]);
endfunction

function automatic logic [bpuPkg::TAG_W-1:0] tagOf(input logic [31:0] pc);
    return pc[31:bpuPkg::INDEX_W+2];
endfunction

function automatic logic lookupHit(input logic [31:0] pc);
    return mdlValid[indexOf(pc)] && (mdlTable[indexOf(pc)].tag == tagOf(pc));
endfunction

function automatic bpuPkg::counterT lookupCount(input logic [31:0] pc);
    return mdlValid[indexOf(pc)] ? mdlTable[indexOf(pc)].count : bpuPkg::cntSNT;
endfunction

// saturating step of a 2-bit counter
function automatic bpuPkg::counterT advanceCount(input bpuPkg::counterT cnt, input logic taken);
    logic [1:0] c;
    c = cnt;
    if (taken && c != 2'd3) begin
        c = c + 2'd1;
    end else if (!taken && c != 2'd0) begin
        c = c - 2'd1;
    end
    return bpuPkg::counterT'(c);
endfunction

task automatic resetModel();
    for (int i = 0; i < 2**bpuPkg::INDEX_W; i++) begin
        mdlValid[i] = 1'b0;
        mdlTable[i] = '0;
    end
    mdlDepth  = 0;
    expTarget = '0;
    expTaken  = 1'b0;
    expType   = bpuPkg::brNone;
    expCount  = bpuPkg::cntSNT;
    expHit    = 1'b0;
    expValid  = 1'b0;
endtask

// one rising edge, using the inputs the DUT samples at that edge
task automatic advanceModel();
    logic [31:0]      top;
    bpuPkg::bhtEntryT e;
    int               i;
    // stack top as the fetch sees it, a call resolving now comes first
    if (resolveValid && resolveType == bpuPkg::brCall) begin
        top = resolvePc + 32'd8;
    end else if (mdlDepth == 0) begin
        top = fetchPc + 32'd8;
    end else begin
        top = mdlStack[mdlDepth-1];
    end
    if (fetchFlush) begin
        expTarget = '0;
        expTaken  = 1'b0;
        expType   = bpuPkg::brNone;
        expHit    = 1'b0;
        expValid  = 1'b0;
    end else if (fetchWr) begin
        e         = mdlTable[indexOf(fetchPc)];
        expHit    = lookupHit(fetchPc);
        expValid  = 1'b1;
        expCount  = e.count;
        expType   = expHit ? e.kind : bpuPkg::brNone;
        expTarget = fetchPc + 32'd8;
        expTaken  = 1'b0;
        if (expHit && (e.kind == bpuPkg::brCall || e.kind == bpuPkg::brRetn ||
                       (e.kind == bpuPkg::brImme && e.count[1]))) begin
            expTaken  = 1'b1;
            expTarget = (e.kind == bpuPkg::brRetn) ? top : e.target;
        end
    end
    if (resolveValid) begin
        i                  = indexOf(resolvePc);
        mdlTable[i].tag    = tagOf(resolvePc);
        mdlTable[i].target = resolveTarget;
        mdlTable[i].kind   = resolveType;
        mdlTable[i].count  = resolveHit ? advanceCount(resolveCount, resolveTaken)
                           : (resolveTaken ? bpuPkg::cntWT : bpuPkg::cntWNT);
        mdlValid[i]        = 1'b1;
        // pushes past the last slot are dropped
        if (resolveType == bpuPkg::brCall && mdlDepth < bpuPkg::RAS_DEPTH) begin
            mdlStack[mdlDepth] = resolvePc + 32'd8;
            mdlDepth++;
        end else if (resolveType == bpuPkg::brRetn && mdlDepth > 0) begin
            mdlDepth--;
        end
    end
endtask

// File: bench/bpuTb.sv
/*
 * Testbench for the branch prediction unit.
 * Random fetch and resolve traffic checked against a reference model.
 */
module bpuTb;
    timeunit 1ns;
    timeprecision 1ns;

    logic               clk = 1'b0;
    logic               arstN;
    logic [31:0]        fetchPc;
    logic               fetchWr;
    logic               fetchFlush;
    logic               resolveValid;
    logic [31:0]        resolvePc;
    logic [31:0]        resolveTarget;
    bpuPkg::branchTypeT resolveType;
    logic               resolveTaken;
    logic               resolveHit;
    bpuPkg::counterT    resolveCount;
    logic [31:0]        predTarget;
    logic               predTaken;
    bpuPkg::branchTypeT predType;
    bpuPkg::counterT    predCount;
    logic               predHit;
    logic               predValid;

    integer seed = 44;
    int     checkCount = 0;
    int     errCount = 0;

    `include "bpuModel.svh"

    branchPredictor branchPredictor_i (.*);

    always #50 clk = ~clk;

    function automatic int randBelow(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // a few tags over a few indices so lookups both hit and alias
    function automatic logic [31:0] poolPc(input int r);
        logic [23:0] tag;
        logic [5:0]  idx;
        tag = (r % 3 == 0) ? 24'h000040 : (r % 3 == 1) ? 24'h00a5c3 : 24'h3f0011;
        idx = (r / 3 == 0) ? 6'd2 : (r / 3 == 1) ? 6'd21 : 6'd50;
        return {tag, idx, 2'b00};
    endfunction

    task automatic checkPred(input logic [31:0] target, input logic taken);
        checkCount += 2;
        if (predTarget !== target) begin
            $display("FAIL predTarget expected %h got %h", target, predTarget);
            errCount++;
        end
        if (predTaken !== taken) begin
            $display("FAIL predTaken expected %h got %h", taken, predTaken);
            errCount++;
        end
    endtask

    task automatic checkInfo(input bpuPkg::branchTypeT kind, input bpuPkg::counterT cnt,
                             input logic hit, input logic valid);
        checkCount += 3;
        if (predType !== kind) begin
            $display("FAIL predType expected %h got %h", kind, predType);
            errCount++;
        end
        if (predHit !== hit) begin
            $display("FAIL predHit expected %h got %h", hit, predHit);
            errCount++;
        end
        if (predValid !== valid) begin
            $display("FAIL predValid expected %h got %h", valid, predValid);
            errCount++;
        end
        // counter only means something on a hit
        if (hit) begin
            checkCount++;
            if (predCount !== cnt) begin
                $display("FAIL predCount expected %h got %h", cnt, predCount);
                errCount++;
            end
        end
    endtask

    // one clock: model the edge, drive the next inputs, check at the falling edge
    task automatic step(input logic [31:0] pc, input logic wr, input logic flush,
                        input logic rv, input logic [31:0] rpc, input logic [31:0] rtgt,
                        input bpuPkg::branchTypeT rtype, input logic rtaken);
        @(posedge clk);
        advanceModel();
        fetchPc       <= pc;
        fetchWr       <= wr;
        fetchFlush    <= flush;
        resolveValid  <= rv;
        resolvePc     <= rpc;
        resolveTarget <= rtgt;
        resolveType   <= rtype;
        resolveTaken  <= rtaken;
        resolveHit    <= lookupHit(rpc);
        resolveCount  <= lookupCount(rpc);
        @(negedge clk);
        checkPred(expTarget, expTaken);
        checkInfo(expType, expCount, expHit, expValid);
    endtask

    task automatic fetchOnly(input logic [31:0] pc);
        step(pc, 1'b1, 1'b0, 1'b0, '0, '0, bpuPkg::brImme, 1'b0);
    endtask

    task automatic resolveWith(input logic [31:0] pc, input logic [31:0] rpc,
                               input bpuPkg::branchTypeT rtype, input logic rtaken);
        step(pc, 1'b1, 1'b0, 1'b1, rpc, 32'h0000_8000 + {rpc[11:2], 2'b00}, rtype, rtaken);
    endtask

    task automatic waitValid();
        int n;
        n = 0;
        while (predValid !== 1'b1 && n < 5) begin
            step(32'h0, 1'b0, 1'b0, 1'b0, '0, '0, bpuPkg::brImme, 1'b0);
            n++;
        end
        if (predValid !== 1'b1) begin
            $display("timeout: predValid stayed low for %0d cycles", n);
            errCount++;
        end
    endtask

    task automatic report(input string name, input int errBefore);
        $display("test %s finished, %0d errors", name, errCount - errBefore);
    endtask

    initial begin
        int                 mark;
        logic [31:0]        holdTarget;
        logic               holdTaken;
        bpuPkg::branchTypeT holdType;
        bpuPkg::counterT    holdCount;
        logic               holdHit;
        fetchPc = '0;
        fetchWr = 1'b0;
        fetchFlush = 1'b0;
        resolveValid = 1'b0;
        resolvePc = '0;
        resolveTarget = '0;
        resolveType = bpuPkg::brImme;
        resolveTaken = 1'b0;
        resolveHit = 1'b0;
        resolveCount = bpuPkg::cntSNT;
        arstN = 1'b0;
        resetModel();
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        mark = errCount;
        fetchOnly(poolPc(randBelow(9)));
        waitValid();
        for (int k = 0; k < 8; k++) begin
            fetchOnly(poolPc(randBelow(9)));
        end
        report("reset and miss", mark);

        mark = errCount;
        for (int k = 0; k < 16; k++) begin
            resolveWith(poolPc(4), poolPc(4), bpuPkg::brImme, randBelow(2) == 1);
            fetchOnly(poolPc(4));
        end
        report("counter training", mark);

        // same index, different tags
        mark = errCount;
        resolveWith(32'h0077_7714, 32'h1234_5614, bpuPkg::brImme, 1'b1);
        fetchOnly(32'h0077_7714);
        fetchOnly(32'h1234_5614);
        resolveWith(32'h1234_5614, 32'h0077_7714, bpuPkg::brImme, 1'b0);
        fetchOnly(32'h1234_5614);
        fetchOnly(32'h0077_7714);
        report("aliasing", mark);

        mark = errCount;
        resolveWith(32'h0, 32'h0000_2008, bpuPkg::brCall, 1'b1);
        fetchOnly(32'h0000_2008);
        resolveWith(32'h0000_2008, 32'h0000_8040, bpuPkg::brRetn, 1'b1);
        resolveWith(32'h0000_8040, 32'h0000_2008, bpuPkg::brCall, 1'b1);
        // call resolving in the fetch cycle of a return
        resolveWith(32'h0000_8040, 32'h0000_3000, bpuPkg::brCall, 1'b1);
        for (int k = 0; k < 10; k++) begin
            resolveWith(32'h0000_8040, 32'h0000_3100 + 32'h100 * k, bpuPkg::brCall, 1'b1);
        end
        for (int k = 0; k < 10; k++) begin
            resolveWith(32'h0000_8040, 32'h0000_8040, bpuPkg::brRetn, 1'b1);
        end
        fetchOnly(32'h0000_8040);
        fetchOnly(32'h0000_8040);
        report("call and return", mark);

        mark = errCount;
        fetchOnly(32'h0000_2008);
        fetchOnly(32'h0000_2008);
        holdTarget = expTarget;
        holdTaken = expTaken;
        holdType = expType;
        holdCount = expCount;
        holdHit = expHit;
        for (int k = 0; k < 6; k++) begin
            step(poolPc(randBelow(9)), 1'b0, 1'b0, 1'b0, '0, '0, bpuPkg::brImme, 1'b0);
            checkPred(holdTarget, holdTaken);
            checkInfo(holdType, holdCount, holdHit, 1'b1);
        end
        step(32'h0000_2008, 1'b1, 1'b1, 1'b0, '0, '0, bpuPkg::brImme, 1'b0);
        fetchOnly(32'h0000_2008);
        waitValid();
        report("stall and flush", mark);

        mark = errCount;
        for (int k = 0; k < 60; k++) begin
            step(poolPc(randBelow(9)), randBelow(4) != 0, randBelow(10) == 0,
                 randBelow(2) == 1, poolPc(randBelow(9)), {$random(seed)} & 32'hffff_fffc,
                 bpuPkg::branchTypeT'(1 + randBelow(3)), randBelow(2) == 1);
        end
        report("random traffic", mark);

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+bench
verilog/bpuPkg.sv
verilog/bhtRam.sv
verilog/counterUpdate.sv
verilog/returnStack.sv
verilog/predictCtrl.sv
verilog/branchPredictor.sv
bench/bpuTb.sv

// File: run.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module bpuTb -o VbpuTb

out=$(./obj_dir/VbpuTb)
echo "$out"
echo "$out" | grep -qx "all tests passed"
